//--- Makefile
SIM      := verilator
TOP      := tb_led_drv
FILELIST := all.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
logic/led_drv_pkg.sv
logic/drv_timer.sv
logic/drv_sequencer.sv
logic/sin_mux.sv
logic/led_drv_top.sv
sim/led_drv_chk.sv
sim/tb_led_drv.sv

//--- logic/drv_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module drv_sequencer
   import led_drv_pkg::*;
#(
   parameter int BLANKING_TIME = 72,
   parameter int GCLK_IDLE     = 512
) (
   input  logic                   clk,
   input  logic                   nrst,
   input  logic                   clk_enable,
   input  logic                   position_sync,
   input  logic                   new_configuration_ready,
   input  logic [STATE_CNT_W-1:0] state_cnt,
   input  logic                   phase_done,
   input  logic                   word_last,
   input  logic                   group_last,
   output drv_state_t             state,
   output logic                   driver_sclk,
   output logic                   driver_gclk,
   output logic                   driver_lat,
   output logic                   column_ready,
   output logic                   driver_ready
);

   drv_state_t next_state;
   logic       reconfig;

   // A new configuration may only cut in while streaming or idle
   assign reconfig = new_configuration_ready
                     && (state inside {BLANKING, PAUSE_SCLK, SHIFT_REGISTER,
                                       WAIT_FOR_NEXT_SLICE});

   always_comb begin
      next_state = state;
      case (state)
         STALL:               if (phase_done) next_state = PREPARE_CONFIG;
         PREPARE_CONFIG:      if (phase_done) next_state = CONFIG;
         CONFIG:              if (phase_done) next_state = WRTFC_TIMING;
         WRTFC_TIMING:        if (phase_done) next_state = PREPARE_DUMP_CONFIG;
         PREPARE_DUMP_CONFIG: if (phase_done) next_state = DUMP_CONFIG;
         DUMP_CONFIG:         if (phase_done) next_state = WAIT_FOR_NEXT_SLICE;
         WAIT_FOR_NEXT_SLICE: if (position_sync) next_state = BLANKING;
         BLANKING:            if (phase_done) next_state = PAUSE_SCLK;
         PAUSE_SCLK:          next_state = SHIFT_REGISTER;
         SHIFT_REGISTER: begin
            if (phase_done) begin
               // Word done, then group done, then slice done
               if (!word_last) begin
                  next_state = PAUSE_SCLK;
               end else if (!group_last) begin
                  next_state = BLANKING;
               end else begin
                  next_state = WAIT_FOR_NEXT_SLICE;
               end
            end
         end
         default:             next_state = STALL;
      endcase
      if (reconfig) begin
         next_state = PREPARE_CONFIG;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         state <= STALL;
      end else if (clk_enable) begin
         state <= next_state;
      end
   end

   // Gated driver clocks, both low on held cycles
   always_comb begin
      driver_sclk = 1'b0;
      driver_gclk = 1'b0;
      case (state)
         // One quiet sclk after FCWRTEN before the data bits
         CONFIG:              driver_sclk = clk_enable && (state_cnt != '0);
         WRTFC_TIMING:        driver_sclk = 1'b0;
         // Readback data starts after DUMP_WAIT quiet cycles
         DUMP_CONFIG:
            driver_sclk = clk_enable && (int'(state_cnt) >= DUMP_WAIT);
         // Keep PWM running for a while, then park gclk
         WAIT_FOR_NEXT_SLICE: driver_gclk = clk_enable && (int'(state_cnt) < GCLK_IDLE);
         BLANKING: begin
            // gclk skips only the first blanking cycle
            driver_gclk = clk_enable && (state_cnt != '0)
                          && (int'(state_cnt) < BLANKING_TIME);
         end
         PAUSE_SCLK:          driver_gclk = clk_enable;
         SHIFT_REGISTER: begin
            driver_sclk = clk_enable;
            driver_gclk = clk_enable;
         end
         // Latch command states need sclk edges
         default:             driver_sclk = clk_enable;
      endcase
   end

   // Latch from the falling edge so it holds past the next rising sclk
   always_ff @(negedge clk or negedge nrst) begin
      if (!nrst) begin
         driver_lat <= 1'b0;
      end else begin
         case (state)
            // FCWRTEN and READFC fill the whole state
            PREPARE_CONFIG, PREPARE_DUMP_CONFIG: driver_lat <= 1'b1;
            // WRTFC over the last bits of the configuration word
            CONFIG: driver_lat <= int'(state_cnt) >= CONF_BITS + 1 - WRTFC_LEN;
            SHIFT_REGISTER: begin
               // WRTGS on every word, LATGS closes the group
               driver_lat <= (state_cnt == STATE_CNT_W'(WORD_BITS - 1))
                             || (word_last
                                 && int'(state_cnt) >= WORD_BITS - LATGS_LEN);
            end
            default: driver_lat <= 1'b0;
         endcase
      end
   end

   assign driver_ready = (state == SHIFT_REGISTER) && clk_enable;

   // Column strobe at each group end and once after the idle gclk run
   assign column_ready = clk_enable
                         && (((state == SHIFT_REGISTER) && word_last && phase_done)
                             || ((state == WAIT_FOR_NEXT_SLICE)
                                 && (int'(state_cnt) == GCLK_IDLE)));

endmodule

`default_nettype wire

//--- logic/drv_timer.sv
`timescale 1ns/100ps
`default_nettype none

module drv_timer
   import led_drv_pkg::*;
#(
   parameter int BLANKING_TIME = 72
) (
   input  logic                   clk,
   input  logic                   nrst,
   input  logic                   clk_enable,
   input  drv_state_t             state,
   output logic [STATE_CNT_W-1:0] state_cnt,
   output logic                   phase_done,
   output logic                   word_last,
   output logic                   group_last
);

   localparam int WORD_CNT_W  = $clog2(WORDS_PER_GROUP);
   localparam int GROUP_CNT_W = $clog2(GROUPS);

   logic [STATE_CNT_W-1:0] cnt_q;
   drv_state_t             last_state;
   logic [WORD_CNT_W-1:0]  word_cnt;
   logic [GROUP_CNT_W-1:0] group_cnt;
   logic                   streaming;
   logic                   word_end;

   // First cycle of a new state reads as zero
   assign state_cnt = (state != last_state) ? '0 : cnt_q;

   // State only moves on enabled cycles, so the compare holds through gaps
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         cnt_q      <= '0;
         last_state <= STALL;
      end else if (clk_enable) begin
         last_state <= state;
         // Saturate so a long wait never wraps back into the gclk window
         cnt_q <= (state_cnt == '1) ? state_cnt : state_cnt + 1'b1;
      end
   end

   // Last cycle of each fixed-length state
   always_comb begin
      case (state)
         STALL:               phase_done = 1'b1;
         PREPARE_CONFIG:      phase_done = state_cnt == STATE_CNT_W'(FCWRTEN_LEN - 1);
         // One idle cycle, then the 48 bits
         CONFIG:              phase_done = state_cnt == STATE_CNT_W'(CONF_BITS);
         WRTFC_TIMING:        phase_done = state_cnt == STATE_CNT_W'(WRTFC_WAIT - 1);
         PREPARE_DUMP_CONFIG: phase_done = state_cnt == STATE_CNT_W'(READFC_LEN - 1);
         DUMP_CONFIG:
            phase_done = state_cnt == STATE_CNT_W'(CONF_BITS + DUMP_WAIT - 1);
         BLANKING:            phase_done = state_cnt == STATE_CNT_W'(BLANKING_TIME - 1);
         PAUSE_SCLK:          phase_done = 1'b1;
         SHIFT_REGISTER:      phase_done = state_cnt == STATE_CNT_W'(WORD_BITS - 1);
         // Open ended, left on position_sync
         default:             phase_done = 1'b0;
      endcase
   end

   assign streaming = state inside {BLANKING, PAUSE_SCLK, SHIFT_REGISTER};
   assign word_end  = (state == SHIFT_REGISTER) && phase_done;

   // Word and group position within the slice
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         word_cnt  <= '0;
         group_cnt <= '0;
      end else if (clk_enable) begin
         if (!streaming) begin
            // Any slice, also one cut by a reconfiguration, starts at group 0
            word_cnt  <= '0;
            group_cnt <= '0;
         end else if (state == BLANKING) begin
            word_cnt <= '0;
         end else if (word_end) begin
            if (word_last) begin
               word_cnt  <= '0;
               group_cnt <= group_last ? '0 : group_cnt + 1'b1;
            end else begin
               word_cnt <= word_cnt + 1'b1;
            end
         end
      end
   end

   assign word_last  = word_cnt == WORD_CNT_W'(WORDS_PER_GROUP - 1);
   assign group_last = group_cnt == GROUP_CNT_W'(GROUPS - 1);

endmodule

`default_nettype wire

//--- logic/led_drv_pkg.sv
`default_nettype none

package led_drv_pkg;

   // Controller states
   typedef enum logic [3:0] {
      STALL,
      PREPARE_CONFIG,
      CONFIG,
      WRTFC_TIMING,
      PREPARE_DUMP_CONFIG,
      DUMP_CONFIG,
      WAIT_FOR_NEXT_SLICE,
      BLANKING,
      PAUSE_SCLK,
      SHIFT_REGISTER
   } drv_state_t;

   // Serial word sizes
   localparam int CONF_BITS = 48;
   // 16 LEDs, 3 colors each
   localparam int WORD_BITS = 48;

   // Latch command lengths, in sclk edges
   localparam int FCWRTEN_LEN = 15;
   localparam int WRTFC_LEN   = 5;
   localparam int READFC_LEN  = 11;
   localparam int LATGS_LEN   = 3;

   // Pause after WRTFC before the readback command
   localparam int WRTFC_WAIT = 6;
   // Silent sclk cycles ahead of the readback data
   localparam int DUMP_WAIT  = 5;

   // Stream layout of one slice
   localparam int WORDS_PER_GROUP = 10;
   localparam int GROUPS          = 8;

   localparam int STATE_CNT_W = 10;

   // LED order for the board layout of drivers UB*D0 and UB*D2
   localparam logic [3:0] LUT0_RG [16] = '{4'd6, 4'd7, 4'd9, 4'd8, 4'd10, 4'd11, 4'd13, 4'd12,
                                           4'd14, 4'd15, 4'd1, 4'd0, 4'd2, 4'd3, 4'd5, 4'd4};
   localparam logic [3:0] LUT0_B [16]  = '{4'd8, 4'd9, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3,
                                           4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd10, 4'd11};

   // LED order for the board layout of drivers UB*D1
   localparam logic [3:0] LUT1_RG [16] = '{4'd2, 4'd3, 4'd5, 4'd4, 4'd6, 4'd7, 4'd9, 4'd8,
                                           4'd10, 4'd11, 4'd13, 4'd12, 4'd14, 4'd15, 4'd1, 4'd0};
   // Blue routing is not symmetric on this board
   localparam logic [3:0] LUT1_B [16]  = '{4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd9, 4'd11,
                                           4'd8, 4'd10, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3};

endpackage

`default_nettype wire

//--- logic/led_drv_top.sv
`timescale 1ns/100ps
`default_nettype none

module led_drv_top
   import led_drv_pkg::*;
#(
   parameter int N_DRIVERS     = 6,
   parameter int BLANKING_TIME = 72,
   parameter int GCLK_IDLE     = 512
) (
   input  logic                 clk,
   input  logic                 nrst,
   input  logic                 clk_enable,
   input  logic                 position_sync,
   input  logic                 new_configuration_ready,
   input  logic [CONF_BITS-1:0] serialized_conf,
   input  logic [WORD_BITS-1:0] data_in [N_DRIVERS-1:0],
   output logic                 driver_sclk,
   output logic                 driver_gclk,
   output logic                 driver_lat,
   output logic [N_DRIVERS-1:0] drivers_sin,
   output logic                 column_ready,
   output logic                 driver_ready
);

   drv_state_t             state;
   logic [STATE_CNT_W-1:0] state_cnt;
   logic                   phase_done;
   logic                   word_last;
   logic                   group_last;

   // Cycle, word and group counters
   drv_timer #(
      .BLANKING_TIME (BLANKING_TIME)
   ) i_timer (
      .clk        (clk),
      .nrst       (nrst),
      .clk_enable (clk_enable),
      .state      (state),
      .state_cnt  (state_cnt),
      .phase_done (phase_done),
      .word_last  (word_last),
      .group_last (group_last)
   );

   // FSM, driver clocks, latch and strobes
   drv_sequencer #(
      .BLANKING_TIME (BLANKING_TIME),
      .GCLK_IDLE     (GCLK_IDLE)
   ) i_sequencer (
      .clk                     (clk),
      .nrst                    (nrst),
      .clk_enable              (clk_enable),
      .position_sync           (position_sync),
      .new_configuration_ready (new_configuration_ready),
      .state_cnt               (state_cnt),
      .phase_done              (phase_done),
      .word_last               (word_last),
      .group_last              (group_last),
      .state                   (state),
      .driver_sclk             (driver_sclk),
      .driver_gclk             (driver_gclk),
      .driver_lat              (driver_lat),
      .column_ready            (column_ready),
      .driver_ready            (driver_ready)
   );

   // Serial data for each driver
   sin_mux #(
      .N_DRIVERS (N_DRIVERS)
   ) i_sin_mux (
      .state           (state),
      .state_cnt       (state_cnt),
      .serialized_conf (serialized_conf),
      .data_in         (data_in),
      .drivers_sin     (drivers_sin)
   );

endmodule

`default_nettype wire

//--- logic/sin_mux.sv
`timescale 1ns/100ps
`default_nettype none

module sin_mux
   import led_drv_pkg::*;
#(
   parameter int N_DRIVERS = 6
) (
   input  drv_state_t             state,
   input  logic [STATE_CNT_W-1:0] state_cnt,
   input  logic [CONF_BITS-1:0]   serialized_conf,
   input  logic [WORD_BITS-1:0]   data_in [N_DRIVERS-1:0],
   output logic [N_DRIVERS-1:0]   drivers_sin
);

   localparam int CONF_IDX_W = $clog2(CONF_BITS);
   localparam int BIT_W      = $clog2(WORD_BITS);

   logic [CONF_IDX_W-1:0] conf_idx;
   logic [1:0]            color;
   logic [3:0]            led;
   logic [3:0]            led_slot;
   logic [3:0]            lut0_pos;
   logic [3:0]            lut1_pos;
   logic [BIT_W-1:0]      lut0_bit;
   logic [BIT_W-1:0]      lut1_bit;

   // MSB first, count 1 carries bit 47
   assign conf_idx = CONF_IDX_W'(STATE_CNT_W'(CONF_BITS) - state_cnt);

   // Three color bits per LED, LEDs in shift order
   assign color    = 2'(state_cnt % STATE_CNT_W'(3));
   assign led      = 4'(state_cnt / STATE_CNT_W'(3));
   assign led_slot = 4'd15 - led;

   // Blue has its own routing on both boards
   assign lut0_pos = (color == 2'd0) ? LUT0_B[led_slot] : LUT0_RG[led_slot];
   assign lut1_pos = (color == 2'd0) ? LUT1_B[led_slot] : LUT1_RG[led_slot];
   assign lut0_bit = BIT_W'(lut0_pos) * BIT_W'(3) + BIT_W'(color);
   assign lut1_bit = BIT_W'(lut1_pos) * BIT_W'(3) + BIT_W'(color);

   always_comb begin
      drivers_sin = '0;
      case (state)
         CONFIG: begin
            // Same configuration on every driver, idle first cycle stays low
            if (state_cnt != '0) begin
               drivers_sin = {N_DRIVERS{serialized_conf[conf_idx]}};
            end
         end
         SHIFT_REGISTER: begin
            for (int i = 0; i < N_DRIVERS; i++) begin
               // Outer thirds of the chain sit on the D1 layout
               if (i < N_DRIVERS / 3 || i >= 2 * N_DRIVERS / 3) begin
                  drivers_sin[i] = data_in[i][lut1_bit];
               end else begin
                  drivers_sin[i] = data_in[i][lut0_bit];
               end
            end
         end
         default: drivers_sin = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- sim/led_drv_chk.sv
`timescale 1ns/100ps
`default_nettype none

module led_drv_chk
   import led_drv_pkg::*;
#(
   parameter int N_DRIVERS = 6
) (
   input logic                 clk,
   input logic                 nrst,
   input logic                 clk_enable,
   input drv_state_t           state,
   input logic                 driver_sclk,
   input logic                 driver_gclk,
   input logic [N_DRIVERS-1:0] drivers_sin
);

   // Driver clocks are gated copies of clk_enable
   sclk_gated: assert property (@(negedge clk) disable iff (!nrst)
      !clk_enable |-> !driver_sclk)
      else $error("driver_sclk high on a held cycle");

   gclk_gated: assert property (@(negedge clk) disable iff (!nrst)
      !clk_enable |-> !driver_gclk)
      else $error("driver_gclk high on a held cycle");

   // Serial data only in the two shifting states
   sin_quiet: assert property (@(negedge clk) disable iff (!nrst)
      (state != CONFIG && state != SHIFT_REGISTER) |-> (drivers_sin == '0))
      else $error("drivers_sin active outside CONFIG and SHIFT_REGISTER");

endmodule

bind led_drv_top led_drv_chk #(
   .N_DRIVERS (N_DRIVERS)
) i_chk (
   .clk          (clk),
   .nrst         (nrst),
   .clk_enable   (clk_enable),
   .state        (state),
   .driver_sclk  (driver_sclk),
   .driver_gclk  (driver_gclk),
   .drivers_sin  (drivers_sin)
);

`default_nettype wire

//--- sim/tb_led_drv.sv
`timescale 1ns/100ps
`default_nettype none

module tb_led_drv
   import led_drv_pkg::*;
();

   localparam int N_DRIVERS     = 6;
   localparam int BLANKING_TIME = 8;
   localparam int GCLK_IDLE     = 512;
   localparam int SEED          = 82540;
   localparam int BIT_W         = $clog2(WORD_BITS);
   localparam int CNT_MAX       = (1 << STATE_CNT_W) - 1;
   // Enabled cycles of one slice, plus the longest idle wait
   localparam int SLICE_CYC = GROUPS * (BLANKING_TIME + WORDS_PER_GROUP * (1 + WORD_BITS))
                              + 1000;
   localparam int CONF_CYC  = 1 + FCWRTEN_LEN + CONF_BITS + 1 + WRTFC_WAIT + READFC_LEN
                              + CONF_BITS + DUMP_WAIT;
   // 10 ns period, about 3 in 4 cycles enabled, then doubled for margin
   localparam int WATCHDOG_NS = (3 * SLICE_CYC + 2 * CONF_CYC) * 10 * 2;

   logic                 clk;
   logic                 nrst;
   logic                 clk_enable;
   logic                 position_sync;
   logic                 new_configuration_ready;
   logic [CONF_BITS-1:0] serialized_conf;
   logic [WORD_BITS-1:0] data_in [N_DRIVERS-1:0];
   logic                 driver_sclk;
   logic                 driver_gclk;
   logic                 driver_lat;
   logic [N_DRIVERS-1:0] drivers_sin;
   logic                 column_ready;
   logic                 driver_ready;

   // Reference model of the controller
   drv_state_t m_st;
   int         m_cnt;
   int         m_word;
   int         m_group;
   int         wait_target;
   int         slices_started;
   int         full_slices;
   logic       reconf_done;
   logic       exp_lat;

   led_drv_top #(
      .N_DRIVERS     (N_DRIVERS),
      .BLANKING_TIME (BLANKING_TIME),
      .GCLK_IDLE     (GCLK_IDLE)
   ) i_dut (
      .clk                     (clk),
      .nrst                    (nrst),
      .clk_enable              (clk_enable),
      .position_sync           (position_sync),
      .new_configuration_ready (new_configuration_ready),
      .serialized_conf         (serialized_conf),
      .data_in                 (data_in),
      .driver_sclk             (driver_sclk),
      .driver_gclk             (driver_gclk),
      .driver_lat              (driver_lat),
      .drivers_sin             (drivers_sin),
      .column_ready            (column_ready),
      .driver_ready            (driver_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout, the controller did not finish the slices in time");
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   task automatic stop_with_failure(input string line);
      $display("%s", line);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
         else stop_with_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h",
                                          name, got, exp));
   endtask

   // Serial bit per driver from the board lookup tables
   function automatic logic [N_DRIVERS-1:0] expected_sin();
      logic [N_DRIVERS-1:0] sin;
      int                   color;
      int                   slot;
      int                   pos;
      sin = '0;
      if (m_st == CONFIG && m_cnt != 0) begin
         // MSB first on all drivers
         sin = {N_DRIVERS{serialized_conf[BIT_W'(CONF_BITS - m_cnt)]}};
      end else if (m_st == SHIFT_REGISTER) begin
         color = m_cnt % 3;
         slot  = 15 - m_cnt / 3;
         for (int i = 0; i < N_DRIVERS; i++) begin
            // Outer thirds use the LUT1 board
            if (i < N_DRIVERS / 3 || i >= 2 * N_DRIVERS / 3) begin
               pos = (color == 0) ? int'(LUT1_B[4'(slot)]) : int'(LUT1_RG[4'(slot)]);
            end else begin
               pos = (color == 0) ? int'(LUT0_B[4'(slot)]) : int'(LUT0_RG[4'(slot)]);
            end
            sin[i] = data_in[i][BIT_W'(pos * 3 + color)];
         end
      end
      return sin;
   endfunction

   task automatic drive_inputs();
      clk_enable = ($urandom % 4) != 0;
      // One reconfiguration, cut into the middle of the second slice
      new_configuration_ready = !reconf_done && slices_started == 2
                                && m_st == SHIFT_REGISTER && m_group == 3;
      if (m_st == WAIT_FOR_NEXT_SLICE) begin
         position_sync = full_slices < 2 && m_cnt >= wait_target;
         if (position_sync) begin
            // Fresh pixel and config data per slice
            serialized_conf = CONF_BITS'({$urandom, $urandom});
            for (int i = 0; i < N_DRIVERS; i++) begin
               data_in[i] = WORD_BITS'({$urandom, $urandom});
            end
         end
      end else begin
         // Sync noise outside the wait has no effect
         position_sync = ($urandom % 8) == 0;
      end
   endtask

   task automatic check_outputs();
      logic en;
      logic exp_sclk;
      logic exp_gclk;
      logic exp_col;
      en       = clk_enable;
      exp_sclk = 1'b0;
      exp_gclk = 1'b0;
      exp_lat  = 1'b0;
      case (m_st)
         STALL, PREPARE_CONFIG, PREPARE_DUMP_CONFIG: begin
            exp_sclk = en;
            exp_lat  = m_st != STALL;
         end
         CONFIG: begin
            exp_sclk = en && m_cnt != 0;
            // Write latch over the last 5 bits
            exp_lat  = m_cnt > CONF_BITS - WRTFC_LEN;
         end
         DUMP_CONFIG:         exp_sclk = en && m_cnt >= DUMP_WAIT;
         WAIT_FOR_NEXT_SLICE: exp_gclk = en && m_cnt < GCLK_IDLE;
         BLANKING:            exp_gclk = en && m_cnt != 0;
         PAUSE_SCLK:          exp_gclk = en;
         SHIFT_REGISTER: begin
            exp_sclk = en;
            exp_gclk = en;
            exp_lat  = m_cnt == WORD_BITS - 1
                       || (m_word == WORDS_PER_GROUP - 1 && m_cnt >= WORD_BITS - LATGS_LEN);
         end
         default: ;
      endcase
      exp_col = en && ((m_st == SHIFT_REGISTER && m_word == WORDS_PER_GROUP - 1
                        && m_cnt == WORD_BITS - 1)
                       || (m_st == WAIT_FOR_NEXT_SLICE && m_cnt == GCLK_IDLE));
      check_value("driver_sclk", 64'(driver_sclk), 64'(exp_sclk));
      check_value("driver_gclk", 64'(driver_gclk), 64'(exp_gclk));
      check_value("column_ready", 64'(column_ready), 64'(exp_col));
      check_value("driver_ready", 64'(driver_ready),
                  64'(en && m_st == SHIFT_REGISTER));
      check_value("drivers_sin", 64'(drivers_sin), 64'(expected_sin()));
   endtask

   // Advance the model by one enabled cycle
   task automatic step_model();
      drv_state_t nx;
      logic       word_end;
      if (clk_enable) begin
         nx       = m_st;
         word_end = m_st == SHIFT_REGISTER && m_cnt == WORD_BITS - 1;
         case (m_st)
            STALL:               nx = PREPARE_CONFIG;
            PREPARE_CONFIG:      if (m_cnt == FCWRTEN_LEN - 1) nx = CONFIG;
            CONFIG:              if (m_cnt == CONF_BITS) nx = WRTFC_TIMING;
            WRTFC_TIMING:        if (m_cnt == WRTFC_WAIT - 1) nx = PREPARE_DUMP_CONFIG;
            PREPARE_DUMP_CONFIG: if (m_cnt == READFC_LEN - 1) nx = DUMP_CONFIG;
            DUMP_CONFIG: begin
               if (m_cnt == CONF_BITS + DUMP_WAIT - 1) nx = WAIT_FOR_NEXT_SLICE;
            end
            WAIT_FOR_NEXT_SLICE: if (position_sync) nx = BLANKING;
            BLANKING:            if (m_cnt == BLANKING_TIME - 1) nx = PAUSE_SCLK;
            PAUSE_SCLK:          nx = SHIFT_REGISTER;
            SHIFT_REGISTER: begin
               if (word_end && m_word < WORDS_PER_GROUP - 1) begin
                  nx = PAUSE_SCLK;
               end else if (word_end && m_group < GROUPS - 1) begin
                  nx = BLANKING;
               end else if (word_end) begin
                  nx = WAIT_FOR_NEXT_SLICE;
               end
            end
            default:             nx = STALL;
         endcase
         if (word_end && m_word == WORDS_PER_GROUP - 1) begin
            m_word  = 0;
            m_group = (m_group + 1) % GROUPS;
         end else if (word_end) begin
            m_word++;
         end
         if (new_configuration_ready
             && m_st inside {BLANKING, PAUSE_SCLK, SHIFT_REGISTER, WAIT_FOR_NEXT_SLICE}) begin
            nx          = PREPARE_CONFIG;
            reconf_done = 1'b1;
         end
         if (nx == WAIT_FOR_NEXT_SLICE && m_st != WAIT_FOR_NEXT_SLICE) begin
            wait_target = int'($urandom % 700);
            if (m_st == SHIFT_REGISTER) full_slices++;
         end
         if (nx == BLANKING && m_st == WAIT_FOR_NEXT_SLICE) slices_started++;
         // Any slice restarts at word 0 of group 0
         if (!(nx inside {BLANKING, PAUSE_SCLK, SHIFT_REGISTER})) begin
            m_word  = 0;
            m_group = 0;
         end
         m_cnt = (nx != m_st) ? 0 : ((m_cnt < CNT_MAX) ? m_cnt + 1 : m_cnt);
         m_st  = nx;
      end
   endtask

   initial begin
      void'($urandom(SEED));
      nrst                    = 1'b0;
      clk_enable              = 1'b0;
      position_sync           = 1'b0;
      new_configuration_ready = 1'b0;
      serialized_conf         = '0;
      for (int i = 0; i < N_DRIVERS; i++) begin
         data_in[i] = '0;
      end
      m_st           = STALL;
      m_cnt          = 0;
      m_word         = 0;
      m_group        = 0;
      slices_started = 0;
      full_slices    = 0;
      reconf_done    = 1'b0;
      exp_lat        = 1'b0;
      // First wait runs past the gclk idle window
      wait_target    = GCLK_IDLE + 20 + int'($urandom % 100);
      repeat (2) @(posedge clk);
      #1 nrst = 1'b1;
      while (!(full_slices == 2 && m_st == WAIT_FOR_NEXT_SLICE && m_cnt >= 40)) begin
         drive_inputs();
         #3;
         check_outputs();
         // Latch moves on the falling edge
         #2;
         check_value("driver_lat", 64'(driver_lat), 64'(exp_lat));
         step_model();
         @(posedge clk);
         #1;
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
